/* logic/rp_cfg.svh */
//////////////////////////////////////////////////
// data path configuration
// widths, bus regions, register map and board id
//////////////////////////////////////////////////

`ifndef RP_CFG_SVH
`define RP_CFG_SVH

// widths
`define RP_ADC_DW        14            // adc and dac sample width
`define RP_SYS_DW        32            // bus data
`define RP_SYS_AW        32            // bus address
`define RP_REGION_NUM    8             // regions picked by addr[22:20]
`define RP_OFS_W         20            // offset inside one region
`define RP_LED_W         8

// region numbers
`define RP_HK_REGION     3'd0          // housekeeping
`define RP_ANA_REGION    3'd1          // analog setpoints and readback

// housekeeping map
`define RP_HK_ID         32'h0A5C_0001 // read only id word
`define RP_HK_ID_OFS     20'h00000
`define RP_HK_LOOP_OFS   20'h00004     // digital loop in bit 0
`define RP_HK_LED_OFS    20'h00030

// analog map
`define RP_ANA_DAC_A_OFS 20'h00000
`define RP_ANA_DAC_B_OFS 20'h00004
`define RP_ANA_ADC_A_OFS 20'h00010     // read only
`define RP_ANA_ADC_B_OFS 20'h00014     // read only

`endif

/* logic/rp_pkg.sv */
//////////////////////////////////////////////////
// shared types
// samples, bus request and response, address view
//////////////////////////////////////////////////

`include "rp_cfg.svh"

package rp_pkg;

  localparam int REGION_W = $clog2(`RP_REGION_NUM);              // 3 bits
  localparam int UPPER_W  = `RP_SYS_AW - REGION_W - `RP_OFS_W;   // bits above region

  // two's complement sample, one channel
  typedef logic signed [`RP_ADC_DW-1:0] sample_t;

  typedef struct packed {
    sample_t a;  // channel 1
    sample_t b;  // channel 2
  } sample_pair_t;

  // address split as the decoder sees it
  typedef struct packed {
    logic [UPPER_W-1:0]   upper;   // not decoded
    logic [REGION_W-1:0]  region;  // addr[22:20]
    logic [`RP_OFS_W-1:0] offset;  // register inside region
  } sys_addr_fields_t;

  // same word, flat or split
  typedef union packed {
    logic [`RP_SYS_AW-1:0] raw;
    sys_addr_fields_t      fields;
  } sys_addr_u;

  typedef struct packed {
    sys_addr_u             addr;
    logic [`RP_SYS_DW-1:0] wdata;
    logic [3:0]            sel;    // byte select, not decoded
    logic                  wen;    // one cycle pulse
    logic                  ren;    // one cycle pulse
  } sys_req_t;

  typedef struct packed {
    logic [`RP_SYS_DW-1:0] rdata;  // valid with ack
    logic                  err;
    logic                  ack;
  } sys_rsp_t;

endpackage

/* logic/sys_bus_decoder.sv */
//////////////////////////////////////////////////
// system bus decoder
// splits the bus into 8 regions by addr[22:20],
// muxes slave responses, answers empty regions
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "rp_cfg.svh"

module sys_bus_decoder (
  input  logic             adc_clk,    // bus clock
  input  logic             rst_n_i,    // async reset, active low
  input  rp_pkg::sys_req_t sys_req_i,  // from master
  output rp_pkg::sys_rsp_t sys_rsp_o,  // to master
  output rp_pkg::sys_req_t hk_req_o,   // housekeeping slave
  output rp_pkg::sys_req_t ana_req_o,  // analog slave
  input  rp_pkg::sys_rsp_t hk_rsp_i,
  input  rp_pkg::sys_rsp_t ana_rsp_i
);

  import rp_pkg::*;

  logic [`RP_REGION_NUM-1:0] cs;           // one hot region select
  logic                      empty_stb;    // strobe into a region with no slave
  logic                      empty_ack_q;
  sys_rsp_t                  empty_rsp;

  //////////////////////////////////////////////////
  // region select and strobe gating
  //////////////////////////////////////////////////

  assign cs = {{(`RP_REGION_NUM-1){1'b0}}, 1'b1} << sys_req_i.addr.fields.region;

  always_comb
  begin
    hk_req_o      = sys_req_i;                             // addr, data pass through
    hk_req_o.wen  = sys_req_i.wen & cs[`RP_HK_REGION];
    hk_req_o.ren  = sys_req_i.ren & cs[`RP_HK_REGION];
    ana_req_o     = sys_req_i;
    ana_req_o.wen = sys_req_i.wen & cs[`RP_ANA_REGION];
    ana_req_o.ren = sys_req_i.ren & cs[`RP_ANA_REGION];
  end

  // regions 2..7
  assign empty_stb = (sys_req_i.wen | sys_req_i.ren)
                   & ~cs[`RP_HK_REGION] & ~cs[`RP_ANA_REGION];

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      empty_ack_q <= 1'b0;
    else
      empty_ack_q <= empty_stb;  // same latency as real slaves
  end

  assign empty_rsp = '{rdata: '0, err: 1'b0, ack: empty_ack_q};

  //////////////////////////////////////////////////
  // response mux
  //////////////////////////////////////////////////

  // master holds addr until ack, so region is still valid here
  always_comb
  begin
    case (sys_req_i.addr.fields.region)
      `RP_HK_REGION:  sys_rsp_o = hk_rsp_i;
      `RP_ANA_REGION: sys_rsp_o = ana_rsp_i;
      default:        sys_rsp_o = empty_rsp;  // zero data, no error
    endcase
  end

endmodule

/* logic/hk_regs.sv */
//////////////////////////////////////////////////
// housekeeping registers
// id word, led register, digital loop enable
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "rp_cfg.svh"

module hk_regs (
  input  logic                 adc_clk,    // bus clock
  input  logic                 rst_n_i,    // async reset, active low
  input  rp_pkg::sys_req_t     req_i,      // strobes already gated by region
  output rp_pkg::sys_rsp_t     rsp_o,
  output logic                 loop_en_o,  // dac setpoints fed back as adc
  output logic [`RP_LED_W-1:0] led_o
);

  logic [`RP_OFS_W-1:0]  ofs;      // register offset
  logic                  wr_ro;    // write into read only id
  logic                  ack_q;
  logic                  err_q;
  logic [`RP_SYS_DW-1:0] rdata_q;

  assign ofs   = req_i.addr.fields.offset;
  assign wr_ro = req_i.wen && (ofs == `RP_HK_ID_OFS);

  // handshake and writable registers
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
      loop_en_o <= 1'b0;
      led_o     <= '0;
    end
    else
    begin
      ack_q <= req_i.wen | req_i.ren;  // one cycle after strobe
      err_q <= wr_ro;
      if (req_i.wen)
      begin
        case (ofs)
          `RP_HK_LOOP_OFS: loop_en_o <= req_i.wdata[0];
          `RP_HK_LED_OFS:  led_o     <= req_i.wdata[`RP_LED_W-1:0];
          default: ;                     // id and unmapped ignored
        endcase
      end
    end
  end

  // read data, sampled in strobe cycle
  always_ff @(posedge adc_clk)
  begin
    case (ofs)
      `RP_HK_ID_OFS:   rdata_q <= `RP_HK_ID;
      `RP_HK_LOOP_OFS: rdata_q <= {{(`RP_SYS_DW-1){1'b0}}, loop_en_o};
      `RP_HK_LED_OFS:  rdata_q <= {{(`RP_SYS_DW-`RP_LED_W){1'b0}}, led_o};
      default:         rdata_q <= '0;   // unmapped reads zero
    endcase
  end

  assign rsp_o = '{rdata: rdata_q, err: err_q, ack: ack_q};

endmodule

/* logic/analog_regs.sv */
//////////////////////////////////////////////////
// analog registers
// two dac setpoints and readback of the current
// adc samples, sign extended to the bus width
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "rp_cfg.svh"

module analog_regs (
  input  logic                 adc_clk,    // bus clock
  input  logic                 rst_n_i,    // async reset, active low
  input  rp_pkg::sys_req_t     req_i,      // gated request
  output rp_pkg::sys_rsp_t     rsp_o,
  input  rp_pkg::sample_pair_t adc_smp_i,  // converted samples from front end
  output rp_pkg::sample_pair_t dac_set_o   // setpoints to back end
);

  import rp_pkg::*;

  logic [`RP_OFS_W-1:0]  ofs;
  logic                  wr_ro;      // write into adc readback
  logic                  ack_q;
  logic                  err_q;
  logic [`RP_SYS_DW-1:0] rdata_q;
  sample_pair_t          dac_set_q;  // setpoint registers

  // sample to bus word
  function automatic logic [`RP_SYS_DW-1:0] sext(input sample_t s);
    sext = {{(`RP_SYS_DW-`RP_ADC_DW){s[`RP_ADC_DW-1]}}, s};
  endfunction

  assign ofs   = req_i.addr.fields.offset;
  assign wr_ro = req_i.wen
              && ((ofs == `RP_ANA_ADC_A_OFS) || (ofs == `RP_ANA_ADC_B_OFS));

  //////////////////////////////////////////////////
  // handshake and setpoints
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
      dac_set_q <= '0;    // mid scale on the dac
    end
    else
    begin
      ack_q <= req_i.wen | req_i.ren;
      err_q <= wr_ro;
      if (req_i.wen)
      begin
        case (ofs)
          `RP_ANA_DAC_A_OFS: dac_set_q.a <= req_i.wdata[`RP_ADC_DW-1:0];  // low 14 bits
          `RP_ANA_DAC_B_OFS: dac_set_q.b <= req_i.wdata[`RP_ADC_DW-1:0];
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////

  // adc value as present in the strobe cycle
  always_ff @(posedge adc_clk)
  begin
    case (ofs)
      `RP_ANA_DAC_A_OFS: rdata_q <= sext(dac_set_q.a);
      `RP_ANA_DAC_B_OFS: rdata_q <= sext(dac_set_q.b);
      `RP_ANA_ADC_A_OFS: rdata_q <= sext(adc_smp_i.a);
      `RP_ANA_ADC_B_OFS: rdata_q <= sext(adc_smp_i.b);
      default:           rdata_q <= '0;
    endcase
  end

  assign rsp_o     = '{rdata: rdata_q, err: err_q, ack: ack_q};
  assign dac_set_o = dac_set_q;

endmodule

/* logic/analog_io.sv */
//////////////////////////////////////////////////
// analog front and back end
// adc capture and slope conversion, digital loop,
// dac conversion and output register
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "rp_cfg.svh"

module analog_io (
  input  logic                  adc_clk,      // sample clock
  input  logic                  rst_n_i,      // async reset, active low
  input  logic [`RP_ADC_DW-1:0] adc_dat_a_i,  // raw adc, negative slope
  input  logic [`RP_ADC_DW-1:0] adc_dat_b_i,
  input  logic                  loop_en_i,    // digital loop
  input  rp_pkg::sample_pair_t  dac_set_i,    // signed setpoints
  output rp_pkg::sample_pair_t  adc_smp_o,    // two's complement samples
  output logic [`RP_ADC_DW-1:0] dac_dat_a_o,  // to dac pins
  output logic [`RP_ADC_DW-1:0] dac_dat_b_o
);

  import rp_pkg::*;

  // dac word for a zero setpoint
  localparam logic [`RP_ADC_DW-1:0] DAC_IDLE = {1'b0, {(`RP_ADC_DW-1){1'b1}}};

  logic [`RP_ADC_DW-1:0] adc_raw_a;  // input registers
  logic [`RP_ADC_DW-1:0] adc_raw_b;
  sample_pair_t          adc_conv;

  // sign bit kept, rest inverted; works in both directions
  function automatic logic [`RP_ADC_DW-1:0] flip_slope(input logic [`RP_ADC_DW-1:0] d);
    flip_slope = {d[`RP_ADC_DW-1], ~d[`RP_ADC_DW-2:0]};
  endfunction

  //////////////////////////////////////////////////
  // adc side
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    adc_raw_a <= adc_dat_a_i;
    adc_raw_b <= adc_dat_b_i;
  end

  assign adc_conv  = '{a: flip_slope(adc_raw_a), b: flip_slope(adc_raw_b)};
  assign adc_smp_o = loop_en_i ? dac_set_i : adc_conv;  // loop bypasses the pins

  //////////////////////////////////////////////////
  // dac side
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_dat_a_o <= DAC_IDLE;
      dac_dat_b_o <= DAC_IDLE;
    end
    else
    begin
      dac_dat_a_o <= flip_slope(dac_set_i.a);  // back to negative slope
      dac_dat_b_o <= flip_slope(dac_set_i.b);
    end
  end

endmodule

/* logic/rp_top.sv */
//////////////////////////////////////////////////
// board top, single clock
// bus decoder, register blocks and analog path
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "rp_cfg.svh"

module rp_top (
  input  logic                  adc_clk,      // adc clock, also bus clock
  input  logic                  rst_n_i,      // async reset, active low
  input  rp_pkg::sys_req_t      sys_req_i,    // system bus master
  output rp_pkg::sys_rsp_t      sys_rsp_o,
  input  logic [`RP_ADC_DW-1:0] adc_dat_a_i,  // adc ch1
  input  logic [`RP_ADC_DW-1:0] adc_dat_b_i,  // adc ch2
  output logic [`RP_ADC_DW-1:0] dac_dat_a_o,  // dac ch1
  output logic [`RP_ADC_DW-1:0] dac_dat_b_o,  // dac ch2
  output logic [`RP_LED_W-1:0]  led_o
);

  import rp_pkg::*;

  sys_req_t     hk_req;
  sys_req_t     ana_req;
  sys_rsp_t     hk_rsp;
  sys_rsp_t     ana_rsp;
  logic         loop_en;   // hk to analog path
  sample_pair_t dac_set;   // setpoints
  sample_pair_t adc_smp;   // samples or loop value

  //////////////////////////////////////////////////
  // bus
  //////////////////////////////////////////////////

  sys_bus_decoder i_dec (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .hk_req_o  (hk_req),     // region 0
    .ana_req_o (ana_req),    // region 1
    .hk_rsp_i  (hk_rsp),
    .ana_rsp_i (ana_rsp)
  );

  hk_regs i_hk (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .req_i     (hk_req),
    .rsp_o     (hk_rsp),
    .loop_en_o (loop_en),
    .led_o     (led_o)
  );

  analog_regs i_ana_regs (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .req_i     (ana_req),
    .rsp_o     (ana_rsp),
    .adc_smp_i (adc_smp),
    .dac_set_o (dac_set)
  );

  //////////////////////////////////////////////////
  // analog path
  //////////////////////////////////////////////////

  analog_io i_ana_io (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i   (loop_en),
    .dac_set_i   (dac_set),
    .adc_smp_o   (adc_smp),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

/* verification/rp_assertions.sv */
//////////////////////////////////////////////////
// bus and reset assertions for the board top
// bound into rp_top
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "rp_cfg.svh"

module rp_assertions (
  input logic                  adc_clk,
  input logic                  rst_n_i,
  input rp_pkg::sys_req_t      sys_req_i,
  input rp_pkg::sys_rsp_t      sys_rsp_o,
  input logic [`RP_ADC_DW-1:0] dac_dat_a_o,
  input logic [`RP_ADC_DW-1:0] dac_dat_b_o
);

  // dac word for a zero setpoint
  localparam logic [`RP_ADC_DW-1:0] DAC_IDLE = {1'b0, {(`RP_ADC_DW-1){1'b1}}};

  int fail_cnt = 0;  // read by the testbench at the end

  logic stb;
  assign stb = sys_req_i.wen || sys_req_i.ren;

  // ack exactly one cycle after each strobe
  a_ack_after_stb: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    stb |=> sys_rsp_o.ack)
  else
  begin
    $error("ack missing one cycle after strobe");
    fail_cnt = fail_cnt + 1;
  end

  a_ack_has_stb: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_rsp_o.ack |-> $past(stb))
  else
  begin
    $error("ack without strobe in the cycle before");
    fail_cnt = fail_cnt + 1;
  end

  a_ack_pulse: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_rsp_o.ack |=> !sys_rsp_o.ack)
  else
  begin
    $error("ack longer than one cycle");
    fail_cnt = fail_cnt + 1;
  end

  a_err_with_ack: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sys_rsp_o.err |-> sys_rsp_o.ack)
  else
  begin
    $error("err outside the ack cycle");
    fail_cnt = fail_cnt + 1;
  end

  // dac idles at mid scale while in reset
  a_dac_reset: assert property (@(posedge adc_clk)
    !rst_n_i |-> (dac_dat_a_o == DAC_IDLE) && (dac_dat_b_o == DAC_IDLE))
  else
  begin
    $error("dac output not at mid scale during reset");
    fail_cnt = fail_cnt + 1;
  end

endmodule

bind rp_top rp_assertions u_asrt (
  .adc_clk     (adc_clk),
  .rst_n_i     (rst_n_i),
  .sys_req_i   (sys_req_i),
  .sys_rsp_o   (sys_rsp_o),
  .dac_dat_a_o (dac_dat_a_o),
  .dac_dat_b_o (dac_dat_b_o)
);

/* verification/rp_tb.sv */
//////////////////////////////////////////////////
// testbench for the single clock board top
// bus timing, led, adc readback, dac setpoints,
// digital loop and empty regions
//////////////////////////////////////////////////

`timescale 1ns/1ns
`include "rp_cfg.svh"

module rp_tb;

  import rp_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int N_RAND     = 8;                      // random values per phase
  localparam int BUS_ACCESSES    = 17 + 12 * N_RAND;  // all phases together
  localparam int WATCHDOG_CYCLES = BUS_ACCESSES * 4 + 100;

  logic                  adc_clk;
  logic                  rst_n;
  sys_req_t              sys_req;
  sys_rsp_t              sys_rsp;
  logic [`RP_ADC_DW-1:0] adc_a;
  logic [`RP_ADC_DW-1:0] adc_b;
  logic [`RP_ADC_DW-1:0] dac_a;
  logic [`RP_ADC_DW-1:0] dac_b;
  logic [`RP_LED_W-1:0]  led;

  logic [15:0] lfsr;              // random state
  sys_rsp_t    exp_q[$];          // expected responses, oldest first
  bit          data_q[$];         // rdata compared for this one
  string       tag_q[$];
  logic        stb_prev = 1'b0;   // strobe seen at last falling edge
  sample_t     set_a;             // last written setpoints
  sample_t     set_b;

  rp_top UUT (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp),
    .adc_dat_a_i (adc_a),
    .adc_dat_b_i (adc_b),
    .dac_dat_a_o (dac_a),
    .dac_dat_b_o (dac_b),
    .led_o       (led)
  );

  initial adc_clk = 1'b0;
  always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;

  //////////////////////////////////////////////////
  // random source and reference model
  //////////////////////////////////////////////////

  // galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v[i] = lfsr[0];         // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // sign bit kept, lower 13 inverted; same rule adc and dac
  function automatic logic [`RP_ADC_DW-1:0] ref_conv(input logic [`RP_ADC_DW-1:0] d);
    ref_conv = d ^ {1'b0, {(`RP_ADC_DW-1){1'b1}}};
  endfunction

  function automatic logic [`RP_SYS_DW-1:0] ref_word(input sample_t s);
    ref_word = int'(s);       // sign extended readback
  endfunction

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rsp(input string tag, input sys_rsp_t got, input sys_rsp_t exp,
                           input bit chk_data);
    if (got.err !== exp.err)
      fail_now($sformatf("Mismatch sys_rsp_o.err (%s): got 0x%0h expected 0x%0h",
                         tag, got.err, exp.err));
    if (chk_data && (got.rdata !== exp.rdata))
      fail_now($sformatf("Mismatch sys_rsp_o.rdata (%s): got 0x%08h expected 0x%08h",
                         tag, got.rdata, exp.rdata));
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp)
      fail_now($sformatf("Mismatch %s: got 0x%04h expected 0x%04h", name, got, exp));
  endtask

  task automatic check_led(input logic [`RP_LED_W-1:0] got, input logic [`RP_LED_W-1:0] exp);
    if (got !== exp)
      fail_now($sformatf("Mismatch led_o: got 0x%02h expected 0x%02h", got, exp));
  endtask

  // every ack checked against the strobe one cycle before
  always @(negedge adc_clk)
  begin
    if (rst_n && stb_prev)
    begin
      if (sys_rsp.ack !== 1'b1)
        fail_now("no ack one cycle after the bus strobe");
      if (exp_q.size() == 0)
        fail_now("ack arrived with no bus access outstanding");
      check_rsp(tag_q.pop_front(), sys_rsp, exp_q.pop_front(), data_q.pop_front());
    end
    else if (rst_n && (sys_rsp.ack === 1'b1))
      fail_now("ack without a strobe in the cycle before");
    stb_prev = rst_n && (sys_req.wen || sys_req.ren);
  end

  //////////////////////////////////////////////////
  // bus master
  //////////////////////////////////////////////////

  task automatic bus_access(input string tag, input logic [2:0] region,
                            input logic [`RP_OFS_W-1:0] ofs, input logic wr,
                            input logic [`RP_SYS_DW-1:0] wdata,
                            input logic [`RP_SYS_DW-1:0] exp_rdata, input logic exp_err);
    sys_req_t req;
    sys_rsp_t exp;
    req.addr.raw = {9'h080, region, ofs};  // 0x4000_0000 base
    req.wdata    = wdata;
    req.sel      = 4'hF;
    req.wen      = wr;
    req.ren      = !wr;
    exp          = '{rdata: exp_rdata, err: exp_err, ack: 1'b1};
    @(posedge adc_clk);
    sys_req <= req;
    exp_q.push_back(exp);
    data_q.push_back(!wr);     // write data not compared
    tag_q.push_back(tag);
    @(posedge adc_clk);
    sys_req.wen <= 1'b0;       // strobe ends, addr held
    sys_req.ren <= 1'b0;
    @(negedge adc_clk);
    while (!sys_rsp.ack)
      @(negedge adc_clk);
  endtask

  task automatic bus_write(input string tag, input logic [2:0] region,
                           input logic [`RP_OFS_W-1:0] ofs, input logic [`RP_SYS_DW-1:0] wdata,
                           input logic exp_err);
    bus_access(tag, region, ofs, 1'b1, wdata, '0, exp_err);
  endtask

  task automatic bus_read(input string tag, input logic [2:0] region,
                          input logic [`RP_OFS_W-1:0] ofs, input logic [`RP_SYS_DW-1:0] exp);
    bus_access(tag, region, ofs, 1'b0, '0, exp, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial
  begin
    logic [31:0] r;
    logic [31:0] w;
    lfsr    = 16'd20925;
    set_a   = '0;
    set_b   = '0;
    rst_n   <= 1'b1;
    sys_req <= '0;
    adc_a   <= '0;
    adc_b   <= '0;
    #(CLK_PERIOD / 4);
    rst_n <= 1'b0;
    repeat (2) @(posedge adc_clk);
    rst_n <= 1'b1;

    // reset state and id
    @(negedge adc_clk);
    check_led(led, '0);
    check_sample("dac_dat_a_o", dac_a, ref_conv('0));
    check_sample("dac_dat_b_o", dac_b, ref_conv('0));
    bus_read("id after reset", `RP_HK_REGION, `RP_HK_ID_OFS, `RP_HK_ID);

    // led register
    for (int i = 0; i < N_RAND; i++)
    begin
      take_bits(`RP_LED_W, r);
      bus_write("led write", `RP_HK_REGION, `RP_HK_LED_OFS, r, 1'b0);
      check_led(led, r[`RP_LED_W-1:0]);  // updated with ack
      bus_read("led readback", `RP_HK_REGION, `RP_HK_LED_OFS, r);
    end

    // adc pins to readback, one cycle input register
    for (int i = 0; i < N_RAND; i++)
    begin
      take_bits(`RP_ADC_DW, r);
      take_bits(`RP_ADC_DW, w);
      @(posedge adc_clk);
      adc_a <= r[`RP_ADC_DW-1:0];
      adc_b <= w[`RP_ADC_DW-1:0];
      bus_read("adc a readback", `RP_ANA_REGION, `RP_ANA_ADC_A_OFS,
               ref_word(ref_conv(r[`RP_ADC_DW-1:0])));
      bus_read("adc b readback", `RP_ANA_REGION, `RP_ANA_ADC_B_OFS,
               ref_word(ref_conv(w[`RP_ADC_DW-1:0])));
    end

    // setpoints, full random word of which 14 bits count
    for (int i = 0; i < N_RAND; i++)
    begin
      take_bits(`RP_SYS_DW, r);
      take_bits(`RP_SYS_DW, w);
      set_a = r[`RP_ADC_DW-1:0];
      set_b = w[`RP_ADC_DW-1:0];
      bus_write("dac a setpoint", `RP_ANA_REGION, `RP_ANA_DAC_A_OFS, r, 1'b0);
      @(negedge adc_clk);                // 2 cycles after strobe
      check_sample("dac_dat_a_o", dac_a, ref_conv(set_a));
      bus_write("dac b setpoint", `RP_ANA_REGION, `RP_ANA_DAC_B_OFS, w, 1'b0);
      @(negedge adc_clk);
      check_sample("dac_dat_b_o", dac_b, ref_conv(set_b));
      bus_read("dac a readback", `RP_ANA_REGION, `RP_ANA_DAC_A_OFS, ref_word(set_a));
      bus_read("dac b readback", `RP_ANA_REGION, `RP_ANA_DAC_B_OFS, ref_word(set_b));
    end

    // digital loop, pins ignored
    bus_write("loop on", `RP_HK_REGION, `RP_HK_LOOP_OFS, 32'd1, 1'b0);
    for (int i = 0; i < N_RAND; i++)
    begin
      take_bits(`RP_ADC_DW, r);
      take_bits(`RP_ADC_DW, w);
      set_a = r[`RP_ADC_DW-1:0];
      set_b = w[`RP_ADC_DW-1:0];
      bus_write("loop setpoint a", `RP_ANA_REGION, `RP_ANA_DAC_A_OFS, r, 1'b0);
      bus_write("loop setpoint b", `RP_ANA_REGION, `RP_ANA_DAC_B_OFS, w, 1'b0);
      take_bits(`RP_ADC_DW, r);
      take_bits(`RP_ADC_DW, w);
      @(posedge adc_clk);
      adc_a <= r[`RP_ADC_DW-1:0];
      adc_b <= w[`RP_ADC_DW-1:0];
      bus_read("loop a readback", `RP_ANA_REGION, `RP_ANA_ADC_A_OFS, ref_word(set_a));
      bus_read("loop b readback", `RP_ANA_REGION, `RP_ANA_ADC_B_OFS, ref_word(set_b));
    end
    bus_write("loop off", `RP_HK_REGION, `RP_HK_LOOP_OFS, 32'd0, 1'b0);
    bus_read("loop readback", `RP_HK_REGION, `RP_HK_LOOP_OFS, 32'd0);

    // regions with no slave, offset 0 is mapped in both slaves
    for (int i = 2; i < `RP_REGION_NUM; i++)
    begin
      bus_read("empty region", 3'(i), `RP_HK_ID_OFS, '0);
    end

    // read only offsets
    take_bits(`RP_SYS_DW, r);
    bus_write("id write", `RP_HK_REGION, `RP_HK_ID_OFS, r, 1'b1);
    bus_read("id after write", `RP_HK_REGION, `RP_HK_ID_OFS, `RP_HK_ID);
    take_bits(`RP_ADC_DW, r);
    take_bits(`RP_ADC_DW, w);
    @(posedge adc_clk);
    adc_a <= r[`RP_ADC_DW-1:0];
    adc_b <= w[`RP_ADC_DW-1:0];
    bus_write("adc a write", `RP_ANA_REGION, `RP_ANA_ADC_A_OFS, ~r, 1'b1);
    bus_write("adc b write", `RP_ANA_REGION, `RP_ANA_ADC_B_OFS, ~w, 1'b1);
    bus_read("adc a after write", `RP_ANA_REGION, `RP_ANA_ADC_A_OFS,
             ref_word(ref_conv(r[`RP_ADC_DW-1:0])));
    bus_read("adc b after write", `RP_ANA_REGION, `RP_ANA_ADC_B_OFS,
             ref_word(ref_conv(w[`RP_ADC_DW-1:0])));
    bus_read("dac a after ro writes", `RP_ANA_REGION, `RP_ANA_DAC_A_OFS, ref_word(set_a));
    check_sample("dac_dat_a_o", dac_a, ref_conv(set_a));
    check_sample("dac_dat_b_o", dac_b, ref_conv(set_b));

    repeat (2) @(negedge adc_clk);     // last assertion samples
    if (UUT.u_asrt.fail_cnt == 0)
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
    begin
      $display("%0d assertion failures", UUT.u_asrt.fail_cnt);
      $display("Result: FAILED");
      $fatal(1, "assertions failed");
    end
  end

  // bounded run time
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge adc_clk);
    fail_now($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
  end

endmodule

/* sources.f */
+incdir+logic
logic/rp_pkg.sv
logic/sys_bus_decoder.sv
logic/hk_regs.sv
logic/analog_regs.sv
logic/analog_io.sv
logic/rp_top.sv
verification/rp_assertions.sv
verification/rp_tb.sv

/* Makefile */
# verilator build and run of rp_tb

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build rp_tb with verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module rp_tb \
		-Mdir obj_dir -o rp_tb_sim
	./obj_dir/rp_tb_sim | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
